//--- logic/cve2_core_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Core support package
// Register file geometry and value types, plus sleep control constants
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package cve2_core_pkg;

  // Register file geometry
  localparam int unsigned RF_NUM_REGS = 32;
  localparam int unsigned RF_ADDR_W   = $clog2(RF_NUM_REGS);
  localparam int unsigned RF_DATA_W   = 32;

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [RF_DATA_W-1:0] rf_data_t;

  // Busy flag value out of reset, core starts asleep
  localparam logic CORE_BUSY_RESET = 1'b0;

endpackage

`default_nettype wire

//--- logic/cve2_icache_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Instruction cache package
// Way and line geometry, tag and line payload types, scramble key
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package cve2_icache_pkg;

  // Cache geometry
  localparam int unsigned IC_NUM_WAYS  = 2;
  localparam int unsigned IC_NUM_LINES = 64;
  localparam int unsigned IC_INDEX_W   = $clog2(IC_NUM_LINES);
  localparam int unsigned IC_TAG_SIZE  = 22;

  // A line is filled by two beats of the 32-bit fetch bus
  localparam int unsigned BUS_SIZE      = 32;
  localparam int unsigned IC_LINE_BEATS = 2;
  localparam int unsigned IC_LINE_SIZE  = BUS_SIZE * IC_LINE_BEATS;

  localparam int unsigned SCRAMBLE_KEY_W = 64;

  typedef logic [IC_INDEX_W-1:0]     ic_index_t;
  typedef logic [IC_TAG_SIZE-1:0]    ic_tag_t;
  typedef logic [IC_LINE_SIZE-1:0]   ic_line_t;
  typedef logic [SCRAMBLE_KEY_W-1:0] scramble_key_t;

  // Key in use until the provider hands over a fresh one
  localparam scramble_key_t SCRAMBLE_KEY_DEFAULT = 64'hC3A5_1E0F_96D2_7B48;

endpackage

`default_nettype wire

//--- logic/cve2_register_file_ff.sv
////////////////////////////////////////////////////////////////////////////
// Flip-flop register file
// 32 x 32 bits, two combinational read ports and one write port
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module cve2_register_file_ff import cve2_core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Read port A
  input  rf_addr_t raddr_a_i,
  output rf_data_t rdata_a_o,

  // Read port B
  input  rf_addr_t raddr_b_i,
  output rf_data_t rdata_b_o,

  // Write port
  input  rf_addr_t waddr_a_i,
  input  rf_data_t wdata_a_i,
  input  logic     we_a_i
);

  rf_data_t rf_reg [RF_NUM_REGS];

  // x0 is hardwired
  assign rf_reg[0] = '0;

  for (genvar i = 1; i < RF_NUM_REGS; i++) begin : gen_regs
    logic     we;
    rf_data_t reg_q;

    assign we = we_a_i & (waddr_a_i == rf_addr_t'(i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        reg_q <= '0;
      end else if (we) begin
        reg_q <= wdata_a_i;
      end
    end

    assign rf_reg[i] = reg_q;
  end

  // Read muxes
  assign rdata_a_o = rf_reg[raddr_a_i];
  assign rdata_b_o = rf_reg[raddr_b_i];

endmodule

`default_nettype wire

//--- logic/cve2_scramble_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Scramble key controller
// Requests a fresh key after a cache invalidate and tracks key validity
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module cve2_scramble_ctrl import cve2_icache_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,

  input  logic          icache_inval_i,

  // Key provider handshake
  input  logic          scramble_key_valid_i,
  input  scramble_key_t scramble_key_i,
  output logic          scramble_req_o,

  // Current key towards the banks
  output scramble_key_t key_o,
  output logic          key_valid_o
);

  scramble_key_t key_q;
  logic          key_valid_d, key_valid_q;
  logic          req_d, req_q;

  // Request held until the provider returns a valid key
  assign req_d = req_q ? ~scramble_key_valid_i : icache_inval_i;

  // Invalid from the invalidate until the key arrives
  assign key_valid_d = icache_inval_i ? 1'b0                 :
                       req_q          ? scramble_key_valid_i :
                                        key_valid_q;

  // Key capture
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q <= SCRAMBLE_KEY_DEFAULT;
    end else if (scramble_key_valid_i) begin
      key_q <= scramble_key_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_valid_q <= 1'b1;
      req_q       <= 1'b0;
    end else begin
      key_valid_q <= key_valid_d;
      req_q       <= req_d;
    end
  end

  assign scramble_req_o = req_q;
  assign key_o          = key_q;
  assign key_valid_o    = key_valid_q;

endmodule

`default_nettype wire

//--- logic/cve2_ic_ram_bank.sv
////////////////////////////////////////////////////////////////////////////
// Instruction cache memory bank
// Single-port array with registered read, XOR-scrambled with the key
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module cve2_ic_ram_bank import cve2_icache_pkg::*; #(
  parameter type payload_t = ic_tag_t
) (
  input  logic          clk_i,
  input  logic          rst_ni,

  input  logic          req_i,
  input  logic          write_i,
  input  ic_index_t     addr_i,
  input  payload_t      wdata_i,
  output payload_t      rdata_o,

  input  scramble_key_t key_i,
  input  logic          key_valid_i
);

  localparam int unsigned PayloadW = $bits(payload_t);

  payload_t mem_q [IC_NUM_LINES];
  payload_t keystream;
  payload_t rdata_q;
  logic     write_en;
  logic     read_en;

  // Low key bits cut to the payload width
  assign keystream = key_i[PayloadW-1:0];

  assign write_en = req_i & write_i & key_valid_i;
  assign read_en  = req_i & ~write_i;

  always_ff @(posedge clk_i) begin
    if (write_en) begin
      mem_q[addr_i] <= wdata_i ^ keystream;
    end
  end

  // Read data holds until the next read of this bank
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (read_en) begin
      if (key_valid_i) begin
        rdata_q <= mem_q[addr_i] ^ keystream;
      end else begin
        // No key, nothing leaks out
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- logic/cve2_top.sv
////////////////////////////////////////////////////////////////////////////
// Core support top level
// Sleep control, register file, scramble key control and cache banks
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module cve2_top import cve2_core_pkg::*, cve2_icache_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Sleep and wake-up
  input  logic                   core_busy_i,
  input  logic                   irq_pending_i,
  input  logic                   irq_nm_i,
  input  logic                   debug_req_i,
  output logic                   core_sleep_o,

  // Register file
  input  rf_addr_t               rf_raddr_a_i,
  output rf_data_t               rf_rdata_a_o,
  input  rf_addr_t               rf_raddr_b_i,
  output rf_data_t               rf_rdata_b_o,
  input  rf_addr_t               rf_waddr_i,
  input  rf_data_t               rf_wdata_i,
  input  logic                   rf_we_i,

  // Tag banks
  input  logic [IC_NUM_WAYS-1:0] ic_tag_req_i,
  input  logic                   ic_tag_write_i,
  input  ic_index_t              ic_tag_addr_i,
  input  ic_tag_t                ic_tag_wdata_i,
  output ic_tag_t                ic_tag_rdata_o [IC_NUM_WAYS],

  // Data banks
  input  logic [IC_NUM_WAYS-1:0] ic_data_req_i,
  input  logic                   ic_data_write_i,
  input  ic_index_t              ic_data_addr_i,
  input  ic_line_t               ic_data_wdata_i,
  output ic_line_t               ic_data_rdata_o [IC_NUM_WAYS],

  // Scrambling
  input  logic                   icache_inval_i,
  input  logic                   scramble_key_valid_i,
  input  scramble_key_t          scramble_key_i,
  output logic                   scramble_req_o
);

  logic          core_busy_q;
  logic          clock_en;
  logic          rf_we;
  scramble_key_t scramble_key;
  logic          scramble_key_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Sleep control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= CORE_BUSY_RESET;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Wake-ups bypass the busy register
  assign clock_en     = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  // Stands in for the gated core clock
  assign rf_we = rf_we_i & clock_en;

  cve2_register_file_ff u_register_file (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .raddr_a_i(rf_raddr_a_i),
    .rdata_a_o(rf_rdata_a_o),
    .raddr_b_i(rf_raddr_b_i),
    .rdata_b_o(rf_rdata_b_o),
    .waddr_a_i(rf_waddr_i),
    .wdata_a_i(rf_wdata_i),
    .we_a_i   (rf_we)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Scrambling and cache banks
  ////////////////////////////////////////////////////////////////////////////

  cve2_scramble_ctrl u_scramble_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .icache_inval_i      (icache_inval_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_req_o      (scramble_req_o),
    .key_o               (scramble_key),
    .key_valid_o         (scramble_key_valid)
  );

  for (genvar way = 0; way < IC_NUM_WAYS; way++) begin : gen_ways
    cve2_ic_ram_bank #(
      .payload_t(ic_tag_t)
    ) u_tag_bank (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .req_i      (ic_tag_req_i[way]),
      .write_i    (ic_tag_write_i),
      .addr_i     (ic_tag_addr_i),
      .wdata_i    (ic_tag_wdata_i),
      .rdata_o    (ic_tag_rdata_o[way]),
      .key_i      (scramble_key),
      .key_valid_i(scramble_key_valid)
    );

    cve2_ic_ram_bank #(
      .payload_t(ic_line_t)
    ) u_data_bank (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .req_i      (ic_data_req_i[way]),
      .write_i    (ic_data_write_i),
      .addr_i     (ic_data_addr_i),
      .wdata_i    (ic_data_wdata_i),
      .rdata_o    (ic_data_rdata_o[way]),
      .key_i      (scramble_key),
      .key_valid_i(scramble_key_valid)
    );
  end

endmodule

`default_nettype wire

//--- sim/cve2_top_sva.sv
////////////////////////////////////////////////////////////////////////////
// Sleep and key handshake assertions, bound into the support top level
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module cve2_top_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic core_busy_i,
  input logic debug_req_i,
  input logic irq_pending_i,
  input logic irq_nm_i,
  input logic core_sleep_i,
  input logic scramble_req_i,
  input logic scramble_key_valid_i
);

  int unsigned fail_count = 0;

  // Request only drops once the provider has answered
  a_req_fall: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(scramble_req_i) |-> $past(scramble_key_valid_i)
  ) else begin
    $error("scramble request fell without a valid key");
    fail_count++;
  end

  // Busy term is the input one cycle back, zero straight out of reset
  a_sleep: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    core_sleep_i == ~(($past(rst_ni) & $past(core_busy_i)) |
                      debug_req_i | irq_pending_i | irq_nm_i)
  ) else begin
    $error("core sleep does not match the wake-up terms");
    fail_count++;
  end

endmodule

bind cve2_top cve2_top_sva u_sva (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .core_busy_i         (core_busy_i),
  .debug_req_i         (debug_req_i),
  .irq_pending_i       (irq_pending_i),
  .irq_nm_i            (irq_nm_i),
  .core_sleep_i        (core_sleep_o),
  .scramble_req_i      (scramble_req_o),
  .scramble_key_valid_i(scramble_key_valid_i)
);

`default_nettype wire

//--- sim/cve2_top_tb.sv
////////////////////////////////////////////////////////////////////////////
// Core support testbench
// Table-driven core model and key provider around the top level
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module cve2_top_tb
  import cve2_core_pkg::*, cve2_icache_pkg::*;
();

  localparam int unsigned SEED         = 38256;
  localparam int unsigned CLK_PERIOD   = 20;
  localparam int unsigned CYCLE_BUDGET = 4;

  typedef enum int {
    OP_RF_WR, OP_RF_RD, OP_TAG_WR, OP_TAG_RD, OP_LINE_WR, OP_LINE_RD,
    OP_INVAL, OP_KEY, OP_WAKE, OP_SLEEP
  } op_e;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   core_busy_i, irq_pending_i, irq_nm_i, debug_req_i;
  logic                   core_sleep_o;
  rf_addr_t               rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i;
  rf_data_t               rf_rdata_a_o, rf_rdata_b_o, rf_wdata_i;
  logic                   rf_we_i;
  logic [IC_NUM_WAYS-1:0] ic_tag_req_i, ic_data_req_i;
  logic                   ic_tag_write_i, ic_data_write_i;
  ic_index_t              ic_tag_addr_i, ic_data_addr_i;
  ic_tag_t                ic_tag_wdata_i;
  ic_tag_t                ic_tag_rdata_o [IC_NUM_WAYS];
  ic_line_t               ic_data_wdata_i;
  ic_line_t               ic_data_rdata_o [IC_NUM_WAYS];
  logic                   icache_inval_i, scramble_key_valid_i, scramble_req_o;
  scramble_key_t          scramble_key_i;

  // Stimulus table
  op_e         step_op [$];
  int          step_way [$];
  int          step_addr [$];
  logic [63:0] step_data [$];
  logic [63:0] step_exp [$];
  string       step_name [$];

  logic        table_ready;
  int unsigned checks;
  int unsigned errors;

  cve2_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic add_step(input op_e op, input int way, input int addr,
                          input logic [63:0] data, input logic [63:0] exp, input string name);
    step_op.push_back(op);
    step_way.push_back(way);
    step_addr.push_back(addr);
    step_data.push_back(data);
    step_exp.push_back(exp);
    step_name.push_back(name);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic drive_idle();
    rf_we_i              = 1'b0;
    ic_tag_req_i         = '0;
    ic_data_req_i        = '0;
    icache_inval_i       = 1'b0;
    scramble_key_valid_i = 1'b0;
  endtask

  task automatic build_table();
    rf_data_t      rf_exp [RF_NUM_REGS];
    ic_tag_t       tag_exp [IC_NUM_WAYS];
    ic_line_t      line_exp [IC_NUM_WAYS];
    scramble_key_t key_a;
    scramble_key_t key_b;
    int            regs [5];
    key_a = SCRAMBLE_KEY_DEFAULT;
    key_b = {$urandom, $urandom};
    regs  = '{0, 1, 5, 17, 31};
    for (int r = 0; r < RF_NUM_REGS; r++) begin
      rf_exp[r] = '0;
      add_step(OP_RF_RD, 0, r, '0, '0, $sformatf("reset read x%0d", r));
    end
    // Busy goes through a register, so sleep clears one cycle later
    add_step(OP_WAKE, 0, 0, 64'h1, 64'h1, "busy same cycle");
    add_step(OP_SLEEP, 0, 0, '0, 64'h0, "busy next cycle");
    foreach (regs[k]) begin
      rf_exp[regs[k]] = (regs[k] == 0) ? '0 : rf_data_t'($urandom);
      add_step(OP_RF_WR, 0, regs[k], 64'(rf_exp[regs[k]]) | 64'h1, '0, "rf write");
      rf_exp[regs[k]] = (regs[k] == 0) ? '0 : rf_exp[regs[k]] | rf_data_t'(1);
    end
    foreach (regs[k]) begin
      add_step(OP_RF_RD, 0, regs[k], '0, 64'(rf_exp[regs[k]]),
               $sformatf("rf read x%0d", regs[k]));
    end
    add_step(OP_WAKE, 0, 0, 64'h0, 64'h0, "busy drop same cycle");
    add_step(OP_SLEEP, 0, 0, '0, 64'h1, "asleep");
    add_step(OP_RF_WR, 0, 5, {$urandom, $urandom}, '0, "rf write asleep");
    add_step(OP_RF_RD, 0, 5, '0, 64'(rf_exp[5]), "rf hold asleep");
    add_step(OP_WAKE, 0, 0, 64'h4, 64'h0, "irq_nm wake");
    add_step(OP_WAKE, 0, 0, 64'h8, 64'h0, "debug wake");
    add_step(OP_WAKE, 0, 0, 64'h2, 64'h0, "irq wake");
    add_step(OP_WAKE, 0, 0, 64'h0, 64'h1, "wake released");
    // Same index in both ways, reset key
    for (int w = 0; w < IC_NUM_WAYS; w++) begin
      tag_exp[w]  = ic_tag_t'($urandom);
      line_exp[w] = {$urandom, $urandom};
      add_step(OP_TAG_WR, w, 9, 64'(tag_exp[w]), '0, "tag write");
      add_step(OP_LINE_WR, w, 9, line_exp[w], '0, "line write");
    end
    for (int w = 0; w < IC_NUM_WAYS; w++) begin
      add_step(OP_TAG_RD, w, 9, '0, 64'(tag_exp[w]), $sformatf("tag read way%0d", w));
      add_step(OP_LINE_RD, w, 9, '0, line_exp[w], $sformatf("line read way%0d", w));
    end
    add_step(OP_INVAL, 0, 0, '0, 64'h1, "request raised");
    add_step(OP_TAG_RD, 0, 9, '0, '0, "tag read no key");
    add_step(OP_LINE_RD, 1, 9, '0, '0, "line read no key");
    add_step(OP_TAG_WR, 0, 9, 64'(~tag_exp[0]), '0, "tag write no key");
    add_step(OP_KEY, 0, 0, key_b, 64'h0, "request dropped");
    // Old entries come back under the old and the new keystream
    for (int w = 0; w < IC_NUM_WAYS; w++) begin
      tag_exp[w]  = tag_exp[w] ^ key_a[IC_TAG_SIZE-1:0] ^ key_b[IC_TAG_SIZE-1:0];
      line_exp[w] = line_exp[w] ^ key_a[IC_LINE_SIZE-1:0] ^ key_b[IC_LINE_SIZE-1:0];
      add_step(OP_TAG_RD, w, 9, '0, 64'(tag_exp[w]), $sformatf("tag rekeyed way%0d", w));
      add_step(OP_LINE_RD, w, 9, '0, line_exp[w], $sformatf("line rekeyed way%0d", w));
    end
    tag_exp[1]  = ic_tag_t'($urandom);
    line_exp[0] = {$urandom, $urandom};
    add_step(OP_TAG_WR, 1, 33, 64'(tag_exp[1]), '0, "tag write new key");
    add_step(OP_LINE_WR, 0, 33, line_exp[0], '0, "line write new key");
    add_step(OP_TAG_RD, 1, 33, '0, 64'(tag_exp[1]), "tag read new key");
    add_step(OP_LINE_RD, 0, 33, '0, line_exp[0], "line read new key");
  endtask

  task automatic run_step(input int i);
    int way;
    way = step_way[i];
    @(negedge clk_i);
    drive_idle();
    case (step_op[i])
      OP_RF_WR: begin
        rf_we_i    = 1'b1;
        rf_waddr_i = rf_addr_t'(step_addr[i]);
        rf_wdata_i = rf_data_t'(step_data[i]);
      end
      OP_RF_RD: begin
        rf_raddr_a_i = rf_addr_t'(step_addr[i]);
        rf_raddr_b_i = rf_addr_t'(step_addr[i]);
        #1;
        check_value({step_name[i], " port a"}, step_exp[i], 64'(rf_rdata_a_o));
        check_value({step_name[i], " port b"}, step_exp[i], 64'(rf_rdata_b_o));
      end
      OP_TAG_WR, OP_TAG_RD: begin
        ic_tag_req_i[way] = 1'b1;
        ic_tag_write_i    = (step_op[i] == OP_TAG_WR);
        ic_tag_addr_i     = ic_index_t'(step_addr[i]);
        ic_tag_wdata_i    = ic_tag_t'(step_data[i]);
        if (step_op[i] == OP_TAG_RD) begin
          @(negedge clk_i);
          drive_idle();
          check_value(step_name[i], step_exp[i], 64'(ic_tag_rdata_o[way]));
        end
      end
      OP_LINE_WR, OP_LINE_RD: begin
        ic_data_req_i[way] = 1'b1;
        ic_data_write_i    = (step_op[i] == OP_LINE_WR);
        ic_data_addr_i     = ic_index_t'(step_addr[i]);
        ic_data_wdata_i    = step_data[i];
        if (step_op[i] == OP_LINE_RD) begin
          @(negedge clk_i);
          drive_idle();
          check_value(step_name[i], step_exp[i], ic_data_rdata_o[way]);
        end
      end
      OP_INVAL, OP_KEY: begin
        icache_inval_i       = (step_op[i] == OP_INVAL);
        scramble_key_valid_i = (step_op[i] == OP_KEY);
        scramble_key_i       = step_data[i];
        @(negedge clk_i);
        drive_idle();
        check_value(step_name[i], step_exp[i], 64'(scramble_req_o));
      end
      OP_WAKE: begin
        {debug_req_i, irq_nm_i, irq_pending_i, core_busy_i} = step_data[i][3:0];
        #1;
        check_value(step_name[i], step_exp[i], 64'(core_sleep_o));
      end
      default: begin
        #1;
        check_value(step_name[i], step_exp[i], 64'(core_sleep_o));
      end
    endcase
  endtask

  initial begin
    void'($urandom(SEED));
    table_ready = 1'b0;
    checks      = 0;
    errors      = 0;
    rst_ni      = 1'b0;
    {core_busy_i, irq_pending_i, irq_nm_i, debug_req_i} = '0;
    {rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i, rf_wdata_i} = '0;
    {ic_tag_write_i, ic_data_write_i, ic_tag_addr_i, ic_data_addr_i} = '0;
    ic_tag_wdata_i  = '0;
    ic_data_wdata_i = '0;
    scramble_key_i  = '0;
    drive_idle();
    build_table();
    table_ready = 1'b1;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_value("reset sleep", 64'h1, 64'(core_sleep_o));
    check_value("reset request", 64'h0, 64'(scramble_req_o));
    foreach (step_op[i]) begin
      run_step(i);
    end
    @(negedge clk_i);
    drive_idle();
    check_value("assertion failures", '0, 64'(uut.u_sva.fail_count));
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    int unsigned limit;
    wait (table_ready);
    limit = (step_op.size() * CYCLE_BUDGET + 8) * CLK_PERIOD;
    #(limit);
    $display("Watchdog expired before the stimulus table completed");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- cve2_top.f
logic/cve2_core_pkg.sv
logic/cve2_icache_pkg.sv
logic/cve2_register_file_ff.sv
logic/cve2_scramble_ctrl.sv
logic/cve2_ic_ram_bank.sv
logic/cve2_top.sv
sim/cve2_top_sva.sv
sim/cve2_top_tb.sv

//--- Makefile
# Verilator build and run for the core support testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := cve2_top_tb
FILELIST := cve2_top.f
OBJ_DIR  := obj_dir
PASS_MSG := Simulation passed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint clean

all: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
